/* sprite_pkg.sv */
// sprite table shared types
`default_nettype none

package sprite_pkg;

	////////////////////////////////////////////////////////////
	// widths

	localparam int COORD_W = 9; // x, y and offset
	localparam int WORD_W  = 32; // data and read words
	localparam int INDEX_W = 5; // suits 32 entries

	////////////////////////////////////////////////////////////
	// field positions inside data and read words

	localparam int OFFSET_LSB = 0;
	localparam int Y_LSB      = 9;
	localparam int X_LSB      = 18;

	// read value when no sprite covers the coordinate
	localparam logic [WORD_W-1:0] NO_HIT_WORD = 32'h0000_0001;

	typedef enum logic [1:0] {
		FIELD_OFFSET = 2'd0,
		FIELD_Y      = 2'd1,
		FIELD_X      = 2'd2 // 3 is not a field
	} field_sel_e;

	////////////////////////////////////////////////////////////
	// structs

	// msb first, so the bits line up with read word [26:0]
	typedef struct packed {
		logic [COORD_W-1:0] x; // bits 26:18
		logic [COORD_W-1:0] y; // bits 17:9
		logic [COORD_W-1:0] offset; // bits 8:0
	} sprite_attr_t;

	// screen position asked about by the display
	typedef struct packed {
		logic [COORD_W-1:0] x;
		logic [COORD_W-1:0] y;
	} check_t;

	typedef struct packed {
		logic [INDEX_W-1:0] index; // 0 is never stored
		field_sel_e         field;
		logic [WORD_W-1:0]  data; // field value sits at its lsb
	} wr_req_t;

endpackage

`default_nettype wire

/* sprite_write_ctrl.sv */
// sprite write control
`timescale 1ns/1ns
`default_nettype none

module sprite_write_ctrl #(
	parameter int NUM_SPRITES = 32
) (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          write,
	input  wire sprite_pkg::wr_req_t     wr_req,
	output logic [NUM_SPRITES-1:0]       entry_we,
	output sprite_pkg::field_sel_e       wr_field,
	output logic [sprite_pkg::COORD_W-1:0] wr_value,
	output logic                         success,
	output logic                         lookup_en
);

	logic idx_ok;
	logic field_ok;
	logic accept;

	////////////////////////////////////////////////////////////
	// write decode

	assign idx_ok = (wr_req.index != '0) && (32'(wr_req.index) < NUM_SPRITES);
	assign field_ok = wr_req.field inside {sprite_pkg::FIELD_OFFSET,
		sprite_pkg::FIELD_Y, sprite_pkg::FIELD_X};
	assign accept = write && idx_ok && field_ok;

	always_comb begin
		entry_we = '0;
		if (accept) begin
			entry_we[wr_req.index] = 1'b1; // single target entry
		end
	end

	assign wr_field = wr_req.field;

	// pull the attribute out of its slot in the data word
	always_comb begin
		case (wr_req.field)
			sprite_pkg::FIELD_OFFSET: wr_value = wr_req.data[sprite_pkg::OFFSET_LSB +: sprite_pkg::COORD_W];
			sprite_pkg::FIELD_Y:      wr_value = wr_req.data[sprite_pkg::Y_LSB +: sprite_pkg::COORD_W];
			sprite_pkg::FIELD_X:      wr_value = wr_req.data[sprite_pkg::X_LSB +: sprite_pkg::COORD_W];
			default:                  wr_value = '0; // rejected anyway
		endcase
	end

	////////////////////////////////////////////////////////////
	// status

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			success <= 1'b0;
		end else begin
			success <= accept; // one cycle after the update edge
		end
	end

	assign lookup_en = !write; // lookups only between writes

	a_we_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(entry_we));

endmodule

`default_nettype wire

/* sprite_reg_bank.sv */
// sprite attribute register bank
`timescale 1ns/1ns
`default_nettype none

module sprite_reg_bank #(
	parameter int NUM_SPRITES = 32
) (
	input  wire                                     clk,
	input  wire                                     rst_n,
	input  wire [NUM_SPRITES-1:0]                   entry_we,
	input  wire sprite_pkg::field_sel_e             wr_field,
	input  wire [sprite_pkg::COORD_W-1:0]           wr_value,
	output sprite_pkg::sprite_attr_t [NUM_SPRITES-1:0] entries,
	output logic [NUM_SPRITES-1:0]                  valid
);

	////////////////////////////////////////////////////////////
	// entry storage

	// only the addressed field moves, the other two keep their value
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			entries <= '0;
			valid   <= '0; // nothing can match after reset
		end else begin
			for (int i = 0; i < NUM_SPRITES; i++) begin
				if (entry_we[i]) begin
					case (wr_field)
						sprite_pkg::FIELD_OFFSET: entries[i].offset <= wr_value;
						sprite_pkg::FIELD_Y:      entries[i].y <= wr_value;
						sprite_pkg::FIELD_X:      entries[i].x <= wr_value;
						default:                  entries[i] <= entries[i];
					endcase
					valid[i] <= 1'b1; // first write makes it live
				end
			end
		end
	end

	// index 0 is filtered out in the write decode
	a_no_entry_zero: assert property (@(posedge clk) disable iff (!rst_n)
		!$rose(valid[0]));

endmodule

`default_nettype wire

/* sprite_hit_detect.sv */
// sprite coordinate comparators
`timescale 1ns/1ns
`default_nettype none

module sprite_hit_detect #(
	parameter int NUM_SPRITES = 32,
	parameter int SPRITE_LINE = 20
) (
	input  wire sprite_pkg::sprite_attr_t [NUM_SPRITES-1:0] entries,
	input  wire [NUM_SPRITES-1:0]                           valid,
	input  wire sprite_pkg::check_t                         check,
	output logic [NUM_SPRITES-1:0]                          hit
);

	// one extra bit so y + SPRITE_LINE - 1 cannot wrap
	localparam int Y_EXT_W = sprite_pkg::COORD_W + 1;

	logic [Y_EXT_W-1:0] chk_y;

	assign chk_y = {1'b0, check.y};

	////////////////////////////////////////////////////////////
	// per entry compare

	for (genvar i = 0; i < NUM_SPRITES; i++) begin : g_cmp
		logic [Y_EXT_W-1:0] y_top;
		logic [Y_EXT_W-1:0] y_bot;
		logic               x_eq;
		logic               y_in;

		assign y_top = {1'b0, entries[i].y};
		assign y_bot = y_top + Y_EXT_W'(SPRITE_LINE - 1); // last line covered
		assign x_eq  = (entries[i].x == check.x);
		assign y_in  = (chk_y >= y_top) && (chk_y <= y_bot);

		assign hit[i] = valid[i] && x_eq && y_in;
	end

endmodule

`default_nettype wire

/* sprite_priority_sel.sv */
// sprite hit priority select
`timescale 1ns/1ns
`default_nettype none

module sprite_priority_sel #(
	parameter int NUM_SPRITES = 32
) (
	input  wire                                     clk,
	input  wire                                     rst_n,
	input  wire                                     lookup_en,
	input  wire [NUM_SPRITES-1:0]                   hit,
	input  wire sprite_pkg::sprite_attr_t [NUM_SPRITES-1:0] entries,
	output logic [sprite_pkg::WORD_W-1:0]           read_data
);

	logic                     found;
	sprite_pkg::sprite_attr_t sel_entry;

	////////////////////////////////////////////////////////////
	// lowest index wins

	always_comb begin
		found     = 1'b0;
		sel_entry = '0;
		for (int i = 0; i < NUM_SPRITES; i++) begin
			if (hit[i] && !found) begin
				found     = 1'b1;
				sel_entry = entries[i];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// output register

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			read_data <= sprite_pkg::NO_HIT_WORD;
		end else if (lookup_en && found) begin
			read_data <= sprite_pkg::WORD_W'(sel_entry); // upper bits zero
		end else begin
			read_data <= sprite_pkg::NO_HIT_WORD; // miss or write cycle
		end
	end

	// a real entry only shows up after a lookup cycle
	a_hit_needs_lookup: assert property (@(posedge clk) disable iff (!rst_n)
		(read_data != sprite_pkg::NO_HIT_WORD) |-> $past(lookup_en));

endmodule

`default_nettype wire

/* sprite_table_top.sv */
// sprite attribute table top
`timescale 1ns/1ns
`default_nettype none

module sprite_table_top #(
	parameter int NUM_SPRITES = 32,
	parameter int SPRITE_LINE = 20
) (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire                           write,
	input  wire sprite_pkg::wr_req_t      wr_req,
	input  wire sprite_pkg::check_t       check,
	output logic [sprite_pkg::WORD_W-1:0] read_data,
	output logic                          success
);

	logic [NUM_SPRITES-1:0]                     entry_we;
	sprite_pkg::field_sel_e                     wr_field;
	logic [sprite_pkg::COORD_W-1:0]             wr_value;
	logic                                       lookup_en;
	sprite_pkg::sprite_attr_t [NUM_SPRITES-1:0] entries;
	logic [NUM_SPRITES-1:0]                     valid;
	logic [NUM_SPRITES-1:0]                     hit;

	////////////////////////////////////////////////////////////
	// control

	sprite_write_ctrl #(
		.NUM_SPRITES(NUM_SPRITES)
	) write_ctrl_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.write    (write),
		.wr_req   (wr_req),
		.entry_we (entry_we),
		.wr_field (wr_field),
		.wr_value (wr_value),
		.success  (success),
		.lookup_en(lookup_en)
	);

	////////////////////////////////////////////////////////////
	// datapath

	sprite_reg_bank #(
		.NUM_SPRITES(NUM_SPRITES)
	) reg_bank_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.entry_we(entry_we),
		.wr_field(wr_field),
		.wr_value(wr_value),
		.entries (entries),
		.valid   (valid)
	);

	sprite_hit_detect #(
		.NUM_SPRITES(NUM_SPRITES),
		.SPRITE_LINE(SPRITE_LINE)
	) hit_detect_i (
		.entries(entries),
		.valid  (valid),
		.check  (check),
		.hit    (hit)
	);

	sprite_priority_sel #(
		.NUM_SPRITES(NUM_SPRITES)
	) priority_sel_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.lookup_en(lookup_en),
		.hit      (hit),
		.entries  (entries),
		.read_data(read_data)
	);

endmodule

`default_nettype wire

/* tb_sprite_table.sv */
// sprite table testbench
`timescale 1ns/1ns
`default_nettype none

module tb_sprite_table;

	localparam int NUM_SPRITES = 32;
	localparam int SPRITE_LINE = 20;
	localparam logic [31:0] NO_HIT = sprite_pkg::NO_HIT_WORD;

	logic                clk = 1'b0;
	logic                rst_n;
	logic                write;
	sprite_pkg::wr_req_t wr_req;
	sprite_pkg::check_t  check;
	logic [31:0]         read_data;
	logic                success;

	// reference model of the table
	logic [8:0] m_x [NUM_SPRITES];
	logic [8:0] m_y [NUM_SPRITES];
	logic [8:0] m_off [NUM_SPRITES];
	logic       m_valid [NUM_SPRITES];

	logic [31:0] pred_read; // what the next edge should produce
	logic        pred_success;
	logic [31:0] exp_read = NO_HIT; // what the last edge should have produced
	logic        exp_success = 1'b0;
	logic        started = 1'b0;
	logic [15:0] lfsr;
	int          errors;
	int          tests;

	sprite_table_top dut_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.write    (write),
		.wr_req   (wr_req),
		.check    (check),
		.read_data(read_data),
		.success  (success)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		exp_read    <= pred_read;
		exp_success <= pred_success;
		started     <= 1'b1;
	end

	////////////////////////////////////////////////////////////
	// checks

	a_read_data: assert property (@(posedge clk) started |-> (read_data == exp_read))
		else begin
			$display("error at %0t: read_data got %h expected %h", $time,
				$sampled(read_data), $sampled(exp_read));
			errors++;
		end

	a_success: assert property (@(posedge clk) started |-> (success == exp_success))
		else begin
			$display("error at %0t: success got %b expected %b", $time,
				$sampled(success), $sampled(exp_success));
			errors++;
		end

	a_reset_read: assert property (@(posedge clk) (started && !rst_n) |=> (read_data == NO_HIT))
		else begin
			$display("error at %0t: read_data got %h expected %h after reset", $time,
				$sampled(read_data), NO_HIT);
			errors++;
		end

	// a write cycle never returns a lookup result
	a_write_block: assert property (@(posedge clk) disable iff (!rst_n)
		write |=> (read_data == NO_HIT))
		else begin
			$display("error at %0t: read_data got %h expected %h after write", $time,
				$sampled(read_data), NO_HIT);
			errors++;
		end

	////////////////////////////////////////////////////////////
	// helpers

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]}; // one step per bit
			lfsr = lfsr_next(lfsr);
		end
	endtask

	function automatic logic [31:0] pack_word(input logic [8:0] x, input logic [8:0] y,
		input logic [8:0] off);
		return (32'(x) << sprite_pkg::X_LSB) | (32'(y) << sprite_pkg::Y_LSB)
			| (32'(off) << sprite_pkg::OFFSET_LSB);
	endfunction

	// lowest valid index covering the coordinate
	function automatic logic [31:0] predict(input logic [8:0] cx, input logic [8:0] cy);
		logic [31:0] word;
		logic        found;
		word  = NO_HIT;
		found = 1'b0;
		for (int i = 1; i < NUM_SPRITES; i++) begin
			if (!found && m_valid[i] && m_x[i] == cx && int'(cy) >= int'(m_y[i])
				&& int'(cy) <= int'(m_y[i]) + SPRITE_LINE - 1) begin
				found = 1'b1;
				word  = pack_word(m_x[i], m_y[i], m_off[i]);
			end
		end
		return word;
	endfunction

	task automatic step();
		@(posedge clk);
		#5; // drive just after the edge
	endtask

	task automatic drive_idle(input logic [8:0] cx, input logic [8:0] cy);
		write        = 1'b0;
		check.x      = cx;
		check.y      = cy;
		pred_read    = predict(cx, cy);
		pred_success = 1'b0;
		step();
	endtask

	task automatic drive_write(input int idx, input logic [1:0] field, input logic [31:0] data);
		logic accepted;
		write         = 1'b1;
		wr_req.index  = 5'(idx);
		wr_req.field  = sprite_pkg::field_sel_e'(field);
		wr_req.data   = data;
		accepted      = (idx != 0) && (idx < NUM_SPRITES) && (field != 2'd3);
		if (accepted) begin
			case (field)
				2'd0: m_off[idx] = data[sprite_pkg::OFFSET_LSB +: 9];
				2'd1: m_y[idx] = data[sprite_pkg::Y_LSB +: 9];
				default: m_x[idx] = data[sprite_pkg::X_LSB +: 9];
			endcase
			m_valid[idx] = 1'b1;
		end
		pred_read    = NO_HIT;
		pred_success = accepted;
		step();
	endtask

	// field values sit in a word of random filler
	task automatic write_field(input int idx, input logic [1:0] field, input logic [8:0] value);
		logic [31:0] data;
		take_bits(32, data);
		case (field)
			2'd0: data[sprite_pkg::OFFSET_LSB +: 9] = value;
			2'd1: data[sprite_pkg::Y_LSB +: 9] = value;
			default: data[sprite_pkg::X_LSB +: 9] = value;
		endcase
		drive_write(idx, field, data);
	endtask

	task automatic write_sprite(input int idx, input logic [8:0] x, input logic [8:0] y,
		input logic [8:0] off);
		write_field(idx, 2'd2, x);
		write_field(idx, 2'd1, y);
		write_field(idx, 2'd0, off);
	endtask

	task automatic wait_success(input int limit);
		int n;
		n = 0;
		while (!success && n < limit) begin
			drive_idle(check.x, check.y);
			n++;
		end
		if (!success) begin
			$display("success pulse did not arrive within %0d cycles", limit);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int err_before);
		drive_idle(check.x, check.y); // let the last check resolve
		tests++;
		$display("test %s: %s", name, (errors == err_before) ? "ok" : "failed");
	endtask

	////////////////////////////////////////////////////////////
	// stimulus

	initial begin
		logic [31:0] r;
		logic [8:0]  x;
		logic [8:0]  y;
		logic [8:0]  off;
		int          idx;
		int          idx_b;
		int          err0;
		rst_n        = 1'b0;
		write        = 1'b0;
		wr_req       = '0;
		check        = '0;
		pred_read    = NO_HIT;
		pred_success = 1'b0;
		lfsr         = 16'd27;
		errors       = 0;
		tests        = 0;
		for (int i = 0; i < NUM_SPRITES; i++) begin
			m_x[i]     = '0;
			m_y[i]     = '0;
			m_off[i]   = '0;
			m_valid[i] = 1'b0;
		end
		repeat (8) @(posedge clk);
		#5;
		rst_n = 1'b1;

		err0 = errors;
		drive_idle(9'd0, 9'd0);
		drive_idle(9'd0, 9'd0);
		end_test("reset", err0);

		err0 = errors;
		take_bits(5, r);
		idx = (r[4:0] == 5'd0) ? 1 : int'(r[4:0]);
		take_bits(9, r);
		x = r[8:0];
		take_bits(8, r);
		y = r[8:0];
		write_field(idx, 2'd2, x);
		wait_success(4);
		drive_idle(x, y);
		write_field(idx, 2'd1, y);
		write_field(idx, 2'd0, 9'd7);
		write_field(0, 2'd2, 9'(x + 9'd3)); // index 0 is dropped
		drive_idle(x, y);
		drive_write(idx, 2'd3, 32'hFFFF_FFFF); // field 3 is dropped
		drive_idle(x, y);
		drive_idle(9'(x + 9'd3), y);
		end_test("success", err0);

		err0 = errors;
		take_bits(5, r);
		idx = (r[4:0] == 5'd0) ? 2 : int'(r[4:0]);
		take_bits(9, r);
		x = r[8:0];
		take_bits(9, r);
		y = r[8:0];
		take_bits(9, r);
		off = r[8:0];
		write_sprite(idx, x, y, off);
		drive_idle(x, y);
		take_bits(8, r);
		y = r[8:0];
		write_field(idx, 2'd1, y); // x and offset must survive
		drive_idle(x, y);
		end_test("field isolation", err0);

		err0 = errors;
		take_bits(5, r);
		idx = (r[4:0] == 5'd0) ? 3 : int'(r[4:0]);
		take_bits(9, r);
		x = r[8:0];
		take_bits(8, r);
		y = r[8:0];
		take_bits(9, r);
		off = r[8:0];
		write_sprite(idx, x, y, off);
		for (int k = 0; k <= SPRITE_LINE; k++) begin
			drive_idle(x, 9'(int'(y) + k)); // last one is just below
		end
		drive_idle(9'(x + 9'd1), y);
		end_test("line range", err0);

		err0 = errors;
		take_bits(4, r);
		idx = (r[3:0] == 4'd0) ? 1 : int'(r[3:0]);
		take_bits(4, r);
		idx_b = idx + 1 + int'(r[3:0]);
		take_bits(9, r);
		x = r[8:0];
		take_bits(8, r);
		y = r[8:0];
		take_bits(9, r);
		off = r[8:0];
		write_sprite(idx_b, x, 9'(y + 9'd5), 9'(off + 9'd1));
		write_sprite(idx, x, y, off);
		drive_idle(x, 9'(y + 9'd10)); // both ranges cover this line
		end_test("priority", err0);

		err0 = errors;
		drive_idle(x, 9'(y + 9'd10));
		write_field(idx_b, 2'd0, 9'd5); // check still matches
		drive_idle(x, 9'(y + 9'd10));
		end_test("write blocks lookup", err0);

		$display("%0d tests, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
sprite_pkg.sv
sprite_write_ctrl.sv
sprite_reg_bank.sv
sprite_hit_detect.sv
sprite_priority_sel.sv
sprite_table_top.sv
tb_sprite_table.sv

/* Makefile */
# Verilator build and run for the sprite attribute table

TOP := tb_sprite_table

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

lint:
	verilator --lint-only --timing -Wall --top-module sprite_table_top \
		sprite_pkg.sv sprite_write_ctrl.sv sprite_reg_bank.sv \
		sprite_hit_detect.sv sprite_priority_sel.sv sprite_table_top.sv
	verilator --lint-only --timing --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir
